/* include/trigger_config.svh */
`ifndef TRIGGER_CONFIG_SVH
`define TRIGGER_CONFIG_SVH

// Input word geometry
// Four ADC samples per valid word, sample 0 in the low bits
`define TRIG_SAMPLES 4

// Signed sample width of the ADC
`define TRIG_ADC_BITS 12

// Frame geometry
// Data words between header and footer
`define TRIG_FRAME_WORDS 16

// Identifier placed in header and footer
`define TRIG_CHANNEL_ID 8'h03

// Pre-trigger length width, 0 to 31 words
`define TRIG_DELAY_BITS 5

`endif

/* logic/triggerPkg.sv */
`default_nettype none

`include "trigger_config.svh"

package triggerPkg;

  // One signed ADC sample
  typedef logic signed [`TRIG_ADC_BITS-1:0] sampleT;

  // Sample minus baseline, one bit wider so it never wraps
  typedef logic signed [`TRIG_ADC_BITS:0] deviationT;

  // Packed input word, sample 0 in the low bits
  typedef logic [`TRIG_SAMPLES*`TRIG_ADC_BITS-1:0] adcWordT;

  // Running count of valid input words
  typedef logic [31:0] stampT;

  // Pre-trigger length in words
  typedef logic [`TRIG_DELAY_BITS-1:0] preLenT;

  // One word of an output frame
  typedef logic [63:0] outWordT;

  // Frame builder states
  // Each state names the word currently on the output
  typedef enum logic [2:0] {
    stateIdle,
    stateHeader,
    stateData,
    stateFlush,
    stateFooter
  } frameStateT;

endpackage

`default_nettype wire

/* logic/sampleStreamIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface sampleStreamIf
  import triggerPkg::*;
();

  // Decoded word, one cycle behind the input strobe
  logic    valid;
  adcWordT word;
  stampT   stamp;
  logic    hit;

  // Same stream delayed by the pre-trigger length
  logic    delayedValid;
  adcWordT delayedWord;
  stampT   delayedStamp;

  modport detect (output valid, word, stamp, hit);

  modport delay (
    input  valid, word, stamp,
    output delayedValid, delayedWord, delayedStamp
  );

  modport build (input valid, word, stamp, hit, delayedValid, delayedWord, delayedStamp);

endinterface

`default_nettype wire

/* logic/hitDetector.sv */
`timescale 1ns/100ps
`default_nettype none

`include "trigger_config.svh"

module hitDetector
  import triggerPkg::*;
(
  input  logic      S_AXIS_ACLK,
  input  logic      arstN,
  input  adcWordT   sTdata,
  input  logic      sTvalid,
  input  sampleT    baseline,
  input  deviationT threshold,
  sampleStreamIf.detect det
);

  deviationT                dev [`TRIG_SAMPLES];
  logic [`TRIG_SAMPLES-1:0] below;
  stampT                    wordCount;

  // Per-sample deviation from the baseline
  // Pulses are negative, so a hit is a deviation at or under the threshold
  always_comb begin
    for (int i = 0; i < `TRIG_SAMPLES; i++) begin
      dev[i] = deviationT'(sampleT'(sTdata[i*`TRIG_ADC_BITS +: `TRIG_ADC_BITS]))
             - deviationT'(baseline);
      below[i] = dev[i] <= threshold;
    end
  end

  // Strobe, hit flag and word counter
  always_ff @(posedge S_AXIS_ACLK or negedge arstN) begin
    if (!arstN) begin
      det.valid <= 1'b0;
      det.hit   <= 1'b0;
      wordCount <= '0;
    end else begin
      det.valid <= sTvalid;
      det.hit   <= sTvalid && (|below);
      if (sTvalid) begin
        wordCount <= wordCount + 32'd1;
      end
    end
  end

  // Word and its stamp captured with the strobe
  always_ff @(posedge S_AXIS_ACLK) begin
    if (sTvalid) begin
      det.word  <= sTdata;
      det.stamp <= wordCount;
    end
  end

endmodule

`default_nettype wire

/* logic/preTriggerDelay.sv */
`timescale 1ns/100ps
`default_nettype none

`include "trigger_config.svh"

module preTriggerDelay
  import triggerPkg::*;
#(
  parameter int depthBits = `TRIG_DELAY_BITS
) (
  input  logic   S_AXIS_ACLK,
  input  logic   arstN,
  input  preLenT preLen,
  sampleStreamIf.delay dly
);

  localparam int depth = 2 ** depthBits;

  // Position k holds the word that came k valid words before the current one
  // Position 0 is the current word on the interface itself
  adcWordT              lineWord  [1:depth-1];
  stampT                lineStamp [1:depth-1];
  logic [depthBits-1:0] fill;
  adcWordT              tapWord;
  stampT                tapStamp;

  always_comb begin
    if (preLen == '0) begin
      tapWord  = dly.word;
      tapStamp = dly.stamp;
    end else begin
      tapWord  = lineWord[preLen];
      tapStamp = lineStamp[preLen];
    end
  end

  // Line advances only on valid words
  always_ff @(posedge S_AXIS_ACLK) begin
    if (dly.valid) begin
      lineWord[1]  <= dly.word;
      lineStamp[1] <= dly.stamp;
      for (int k = 2; k < depth; k++) begin
        lineWord[k]  <= lineWord[k-1];
        lineStamp[k] <= lineStamp[k-1];
      end
      dly.delayedWord  <= tapWord;
      dly.delayedStamp <= tapStamp;
    end
  end

  // Fill level saturates once the whole line is loaded
  always_ff @(posedge S_AXIS_ACLK or negedge arstN) begin
    if (!arstN) begin
      fill             <= '0;
      dly.delayedValid <= 1'b0;
    end else begin
      dly.delayedValid <= dly.valid && (fill >= preLen);
      if (dly.valid && (fill != '1)) begin
        fill <= fill + 1'b1;
      end
    end
  end

  // A change while words flow would mix two tap positions in one frame
  preLenStable: assert property (
    @(posedge S_AXIS_ACLK) disable iff (!arstN)
    dly.valid |-> $stable(preLen)
  );

endmodule

`default_nettype wire

/* logic/frameBuilder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "trigger_config.svh"

module frameBuilder
  import triggerPkg::*;
(
  input  logic    S_AXIS_ACLK,
  input  logic    arstN,
  input  preLenT  preLen,
  sampleStreamIf.build bld,
  output outWordT dout,
  output logic    doutValid
);

  frameStateT                          state, nextState;
  adcWordT                             holdWord;
  logic [$clog2(`TRIG_FRAME_WORDS):0] wordIdx;
  logic                                hitPend;
  stampT                               pendStamp, hitStamp;
  logic [15:0]                         frameCount;
  outWordT                             nextDout, dataWord;
  logic                                nextValid, takeWord, start, lastHeld;

  // Hit of the word whose delayed copy arrives in the next cycle
  always_ff @(posedge S_AXIS_ACLK or negedge arstN) begin
    if (!arstN) begin
      hitPend <= 1'b0;
    end else if (bld.valid) begin
      hitPend <= bld.hit;
    end
  end

  always_ff @(posedge S_AXIS_ACLK) begin
    if (bld.valid) begin
      pendStamp <= bld.stamp;
    end
  end

  assign start    = (state == stateIdle) && bld.delayedValid && hitPend;
  assign lastHeld = wordIdx == `TRIG_FRAME_WORDS - 1;
  assign dataWord = {16'(wordIdx), holdWord};

  always_comb begin
    nextState = state;
    nextDout  = dout;
    nextValid = 1'b0;
    takeWord  = 1'b0;
    case (state)
      stateIdle: begin
        if (start) begin
          nextState = stateHeader;
          nextDout  = {8'hAA, `TRIG_CHANNEL_ID, 16'(preLen), bld.delayedStamp};
          nextValid = 1'b1;
          takeWord  = 1'b1;
        end
      end
      stateHeader, stateData: begin
        nextState = stateData;
        // Last word goes out without waiting for another strobe
        if (lastHeld) begin
          nextState = stateFlush;
          nextDout  = dataWord;
          nextValid = 1'b1;
        end else if (bld.delayedValid) begin
          nextDout  = dataWord;
          nextValid = 1'b1;
          takeWord  = 1'b1;
        end
      end
      stateFlush: begin
        nextState = stateFooter;
        nextDout  = {8'h55, `TRIG_CHANNEL_ID, frameCount, hitStamp};
        nextValid = 1'b1;
      end
      default: nextState = stateIdle;
    endcase
  end

  always_ff @(posedge S_AXIS_ACLK or negedge arstN) begin
    if (!arstN) begin
      state      <= stateIdle;
      doutValid  <= 1'b0;
      wordIdx    <= '0;
      frameCount <= '0;
    end else begin
      state     <= nextState;
      doutValid <= nextValid;
      if (start) begin
        wordIdx    <= '0;
        frameCount <= frameCount + 16'd1;
      end else if (takeWord) begin
        wordIdx <= wordIdx + 1'b1;
      end
    end
  end

  always_ff @(posedge S_AXIS_ACLK) begin
    dout <= nextDout;
    if (takeWord) begin
      holdWord <= bld.delayedWord;
    end
    if (start) begin
      hitStamp <= pendStamp;
    end
  end

  idxInRange: assert property (
    @(posedge S_AXIS_ACLK) disable iff (!arstN)
    (state == stateData) |-> (wordIdx < `TRIG_FRAME_WORDS)
  );

  // Footer must be dropped on the way back to idle
  quietWhenIdle: assert property (
    @(posedge S_AXIS_ACLK) disable iff (!arstN)
    (state == stateIdle) |-> !doutValid
  );

endmodule

`default_nettype wire

/* logic/minimumTrigger.sv */
`timescale 1ns/100ps
`default_nettype none

module minimumTrigger
  import triggerPkg::*;
(
  input  logic      S_AXIS_ACLK,
  input  logic      arstN,
  input  adcWordT   sTdata,
  input  logic      sTvalid,
  input  sampleT    baseline,
  input  deviationT threshold,
  input  preLenT    preLen,
  output outWordT   dout,
  output logic      doutValid
);

  // Decoded stream and its delayed copy
  sampleStreamIf stream ();

  hitDetector det0 (
    .S_AXIS_ACLK (S_AXIS_ACLK),
    .arstN       (arstN),
    .sTdata      (sTdata),
    .sTvalid     (sTvalid),
    .baseline    (baseline),
    .threshold   (threshold),
    .det         (stream.detect)
  );

  preTriggerDelay dly0 (
    .S_AXIS_ACLK (S_AXIS_ACLK),
    .arstN       (arstN),
    .preLen      (preLen),
    .dly         (stream.delay)
  );

  // Header appears three cycles after the hit word on sTdata
  frameBuilder bld0 (
    .S_AXIS_ACLK (S_AXIS_ACLK),
    .arstN       (arstN),
    .preLen      (preLen),
    .bld         (stream.build),
    .dout        (dout),
    .doutValid   (doutValid)
  );

endmodule

`default_nettype wire

/* tests/minimumTriggerTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "trigger_config.svh"

module minimumTriggerTb
  import triggerPkg::*;
();

  logic      S_AXIS_ACLK;
  logic      arstN;
  adcWordT   sTdata;
  logic      sTvalid;
  sampleT    baseline;
  deviationT threshold;
  preLenT    preLen;
  outWordT   dout;
  logic      doutValid;

  // Test table, one entry per data file line
  string       tName [$];
  int          tBase [$];
  int          tThr [$];
  int          tPre [$];
  int          tWords [$];
  int          tPos [$];
  int          tDepth [$];
  int          tPos2 [$];
  logic [31:0] tGap [$];
  logic [31:0] tStamp [$];

  adcWordT     sent [$];
  outWordT     expQ [$];
  string       curName;
  int          errors;
  int          checks;
  int          outIdx;
  int          budget;
  logic [31:0] rngState;

  minimumTrigger dut0 (.*);

  always #50 S_AXIS_ACLK = ~S_AXIS_ACLK;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Noise within 4 codes of the baseline, pulse replaces sample 2
  function automatic adcWordT makeWord(input int base, input int depth, input logic pulse);
    adcWordT w;
    int      v;
    for (int j = 0; j < `TRIG_SAMPLES; j++) begin
      rngState = xorshift(rngState);
      v = base + int'(rngState % 9) - 4;
      if (pulse && j == 2) begin
        v = base - depth;
      end
      w[j*`TRIG_ADC_BITS +: `TRIG_ADC_BITS] = v[`TRIG_ADC_BITS-1:0];
    end
    return w;
  endfunction

  // Any sample at or below baseline plus threshold
  function automatic logic isHit(input adcWordT w, input int base, input int thr);
    sampleT s;
    logic   hit;
    hit = 1'b0;
    for (int j = 0; j < `TRIG_SAMPLES; j++) begin
      s = w[j*`TRIG_ADC_BITS +: `TRIG_ADC_BITS];
      if (int'(s) - base <= thr) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic runTest(input int t);
    int          pre;
    int          freeAt;
    int          frames;
    int          errBefore;
    int          g;
    logic [31:0] gap;
    logic [31:0] firstStamp;
    errBefore = errors;
    pre = tPre[t];
    gap = tGap[t];
    curName = tName[t];
    outIdx = 0;
    @(posedge S_AXIS_ACLK);
    #10;
    arstN = 1'b0;
    sTvalid = 1'b0;
    baseline = tBase[t];
    threshold = tThr[t];
    preLen = pre;
    sent.delete();
    expQ.delete();
    for (int k = 0; k < tWords[t]; k++) begin
      sent.push_back(makeWord(tBase[t], tDepth[t],
                              (tPos[t] > 0 && k == tPos[t]) || (tPos2[t] > 0 && k == tPos2[t])));
    end
    // Reference frames, the builder stays busy a few words past the last data word
    freeAt = 0;
    frames = 0;
    firstStamp = '1;
    for (int k = 0; k < tWords[t]; k++) begin
      if (isHit(sent[k], tBase[t], tThr[t]) && k >= pre && k >= freeAt
          && k + `TRIG_FRAME_WORDS <= tWords[t]) begin
        frames++;
        if (frames == 1) begin
          firstStamp = k;
        end
        expQ.push_back({8'hAA, `TRIG_CHANNEL_ID, 16'(pre), 32'(k - pre)});
        for (int i = 0; i < `TRIG_FRAME_WORDS; i++) begin
          expQ.push_back({16'(i), sent[k-pre+i]});
        end
        expQ.push_back({8'h55, `TRIG_CHANNEL_ID, 16'(frames), 32'(k)});
        freeAt = k + `TRIG_FRAME_WORDS + 4;
      end
    end
    assert (firstStamp == tStamp[t]) else begin
      errors++;
      $display("Test %s: data file expects hit stamp %h but the stimulus hits at %h",
               curName, tStamp[t], firstStamp);
    end
    repeat (5) @(posedge S_AXIS_ACLK);
    #10 arstN = 1'b1;
    for (int k = 0; k < tWords[t]; k++) begin
      g = gap[k % 32] ? 1 + k % 3 : 0;
      repeat (g) begin
        @(posedge S_AXIS_ACLK);
        #10 sTvalid = 1'b0;
      end
      @(posedge S_AXIS_ACLK);
      #10;
      sTdata = sent[k];
      sTvalid = 1'b1;
    end
    @(posedge S_AXIS_ACLK);
    #10 sTvalid = 1'b0;
    while (expQ.size() != 0) begin
      @(posedge S_AXIS_ACLK);
    end
    // Quiet tail catches extra frames
    repeat (20) @(posedge S_AXIS_ACLK);
    $display("Test %s: %0d frames, %0d words checked, %0d errors",
             curName, frames, outIdx, errors - errBefore);
  endtask

  // Outputs settle well before the falling edge
  always @(negedge S_AXIS_ACLK) begin
    if (arstN && doutValid) begin
      assert (expQ.size() != 0) else begin
        errors++;
        $display("Test %s produced output word %h where no frame was expected", curName, dout);
      end
      if (expQ.size() != 0) begin
        checks++;
        assert (dout == expQ[0]) else begin
          errors++;
          $display("[ERROR] %s word %0d: expected %h, actual %h", curName, outIdx, expQ[0], dout);
        end
        void'(expQ.pop_front());
        outIdx++;
      end
    end
  end

  initial begin
    wait (budget > 0);
    repeat (budget) @(posedge S_AXIS_ACLK);
    $display("Timeout: the tests did not finish within %0d clock cycles", budget);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int          fd;
    int          n;
    string       line;
    string       nm;
    int          b, th, pl, wc, ps, dp, ps2;
    logic [31:0] gp, st;
    S_AXIS_ACLK = 1'b0;
    arstN = 1'b0;
    sTdata = '0;
    sTvalid = 1'b0;
    baseline = '0;
    threshold = '0;
    preLen = '0;
    rngState = 32'h2972_5e3f;
    errors = 0;
    checks = 0;
    budget = 0;
    fd = $fopen("tests/trigger_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the test data file tests/trigger_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%s %d %d %d %d %d %d %d %h %h", nm, b, th, pl, wc, ps, dp, ps2, gp, st);
        if (line.getc(0) != "#" && n == 10) begin
          tName.push_back(nm);
          tBase.push_back(b);
          tThr.push_back(th);
          tPre.push_back(pl);
          tWords.push_back(wc);
          tPos.push_back(ps);
          tDepth.push_back(dp);
          tPos2.push_back(ps2);
          tGap.push_back(gp);
          tStamp.push_back(st);
        end
      end
      $fclose(fd);
    end
    budget = 200;
    foreach (tWords[i]) begin
      budget += 4 * tWords[i];
    end
    for (int t = 0; t < tName.size(); t++) begin
      runTest(t);
    end
    $display("Tests run: %0d, words checked: %0d, errors: %0d", tName.size(), checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/trigger_testdata.txt */
# name baseline threshold preLen words pulse depth pulse2 gapMask(hex) hitStamp(hex)
# Pulse positions count valid words from 0 after reset, 0 is no pulse, ffffffff is no frame
basicPre4     100 -200  4 48 10 400  0 00000000 0000000a
thrEqual        0 -150  4 40 12 150  0 00000000 0000000c
thrShallow      0 -150  4 40 12 149  0 00000000 ffffffff
preLenZero    -50 -300  0 40  5 500  0 00000000 00000005
preLenMax     200 -300 31 64 40 600  0 00000000 00000028
busyInside      0 -100  4 72 10 300 16 00000000 0000000a
busyAfter       0 -100  4 72 10 300 40 00000000 0000000a
inputGaps      50 -200  6 48 20 350  0 5a3c9617 00000014
resetQuiet      0 -100  4  0  0   0  0 00000000 ffffffff

/* sim.f */
+incdir+include
logic/triggerPkg.sv
logic/sampleStreamIf.sv
logic/hitDetector.sv
logic/preTriggerDelay.sv
logic/frameBuilder.sv
logic/minimumTrigger.sv
tests/minimumTriggerTb.sv

/* Bender.yml */
package:
  name: minimum_trigger

export_include_dirs:
  - include

sources:
  - files:
      - logic/triggerPkg.sv
      - logic/sampleStreamIf.sv
      - logic/hitDetector.sv
      - logic/preTriggerDelay.sv
      - logic/frameBuilder.sv
      - logic/minimumTrigger.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/minimumTriggerTb.sv
